/* rtl/fp_add_pkg.sv */
package fp_add_pkg;

   // ------------------------------
   // ieee single widths
   // ------------------------------
   localparam int WORD_W  = 32;                    // full word
   localparam int EXP_W   = 8;                     // biased exponent
   localparam int MANT_W  = 23;                    // stored fraction bits
   localparam int GUARD_W = 2;                     // extra bits below lsb
   localparam int FRAC_W  = 1 + MANT_W + GUARD_W;  // hidden + stored + guard
   localparam int ADDR_W  = 3;                     // slave word address

   typedef logic [WORD_W-1:0] fp_word_t;   // packed float
   typedef logic [EXP_W-1:0]  exp_t;       // biased exponent
   typedef logic [FRAC_W-1:0] frac_t;      // working fraction
   typedef logic [ADDR_W-1:0] wb_addr_t;   // word offset
   typedef logic [WORD_W-1:0] wb_data_t;   // bus data

   localparam exp_t EXP_MAX_NORM = 8'd254; // kept on overflow

   // ------------------------------
   // register map
   // ------------------------------
   localparam wb_addr_t REG_OP_A   = 3'd0;  // operand a
   localparam wb_addr_t REG_OP_B   = 3'd1;  // operand b
   localparam wb_addr_t REG_CTRL   = 3'd2;  // write launches op
   localparam wb_addr_t REG_STATUS = 3'd3;  // busy + done count, ro
   localparam wb_addr_t REG_RESULT = 3'd4;  // last result, ro

   localparam int CTRL_SUB_BIT = 0;        // 1 = a - b

   // slave handshake states
   typedef enum logic {
      ST_IDLE,   // waiting for cyc & stb
      ST_ACK     // one-cycle ack
   } wb_state_t;

endpackage

/* rtl/fp_align.sv */
`timescale 1ns/1ps

module fp_align import fp_add_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  fp_word_t a,
   input  fp_word_t b,
   input  logic     sub,
   output logic     out_valid,
   output frac_t    frac_big,
   output frac_t    frac_small,
   output logic     sign_big,
   output logic     sign_small_eff,
   output exp_t     exp_big
);

   exp_t  exp_a;       // unpacked fields
   exp_t  exp_b;
   frac_t frac_a;
   frac_t frac_b;
   logic  sign_a;
   logic  sign_b;      // after sub inversion
   logic  a_is_big;    // a has larger magnitude
   exp_t  exp_hi;
   exp_t  exp_lo;
   exp_t  exp_diff;    // right shift amount
   frac_t frac_hi;
   frac_t frac_lo;
   frac_t frac_lo_sh;  // aligned small fraction
   logic  sign_hi;
   logic  sign_lo;

   // ------------------------------
   // unpack and order
   // ------------------------------
   always_comb begin
      sign_a = a[WORD_W-1];
      sign_b = b[WORD_W-1] ^ sub;                      // a - b is a + (-b)
      exp_a  = a[WORD_W-2 -: EXP_W];
      exp_b  = b[WORD_W-2 -: EXP_W];
      frac_a = (exp_a == '0) ? '0 : {1'b1, a[MANT_W-1:0], {GUARD_W{1'b0}}};  // exp 0 is zero
      frac_b = (exp_b == '0) ? '0 : {1'b1, b[MANT_W-1:0], {GUARD_W{1'b0}}};
      // exponent first, fraction breaks ties
      a_is_big = (exp_a > exp_b) || ((exp_a == exp_b) && (frac_a >= frac_b));
      if (a_is_big) begin
         exp_hi  = exp_a;
         exp_lo  = exp_b;
         frac_hi = frac_a;
         frac_lo = frac_b;
         sign_hi = sign_a;
         sign_lo = sign_b;
      end else begin
         exp_hi  = exp_b;
         exp_lo  = exp_a;
         frac_hi = frac_b;
         frac_lo = frac_a;
         sign_hi = sign_b;
         sign_lo = sign_a;
      end
      exp_diff = exp_hi - exp_lo;                      // never negative here
      if (exp_diff >= FRAC_W) frac_lo_sh = '0;         // shifted out past guards
      else                    frac_lo_sh = frac_lo >> exp_diff;
   end

   // stage register
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      frac_big       <= frac_hi;      // payload, no reset
      frac_small     <= frac_lo_sh;
      sign_big       <= sign_hi;
      sign_small_eff <= sign_lo;
      exp_big        <= exp_hi;
   end

endmodule

/* rtl/fp_frac_sub.sv */
`timescale 1ns/1ps

module fp_frac_sub import fp_add_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  in_valid,
   input  frac_t frac1,
   input  frac_t frac2,
   input  logic  sign1,
   input  logic  sign2,
   input  exp_t  exp_in,
   output logic  out_valid,
   output frac_t sum,
   output logic  sign_out,
   output logic  carry_out,
   output exp_t  exp_out
);

   logic [FRAC_W:0] ext1;      // 27 bit, top bit for carry / sign
   logic [FRAC_W:0] ext2;
   logic [FRAC_W:0] sum_add;
   logic [FRAC_W:0] sum_dif;   // two's complement difference
   logic [FRAC_W:0] mag;
   logic            same_sign;
   logic            neg;       // difference went below zero
   logic            sign_c;
   logic            carry_c;
   exp_t            exp_c;

   // ------------------------------
   // signed combine
   // ------------------------------
   always_comb begin
      ext1      = {1'b0, frac1};
      ext2      = {1'b0, frac2};
      same_sign = (sign1 == sign2);
      sum_add   = ext1 + ext2;
      sum_dif   = ext1 + ~ext2 + 1'b1;             // ext1 - ext2
      neg       = ~same_sign & sum_dif[FRAC_W];
      if (same_sign) begin
         mag    = sum_add;                         // may carry into bit 26
         sign_c = sign1;
      end else if (neg) begin
         mag    = -sum_dif;                        // only if frac2 was larger
         sign_c = sign2;
      end else begin
         mag    = sum_dif;
         sign_c = sign1;
      end
      carry_c = same_sign & mag[FRAC_W];
      exp_c   = (mag == '0) ? '0 : exp_in;         // flag exact cancellation
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      sum       <= mag[FRAC_W-1:0];   // magnitude without carry
      sign_out  <= sign_c;
      carry_out <= carry_c;
      exp_out   <= exp_c;
   end

endmodule

/* rtl/fp_normalize.sv */
`timescale 1ns/1ps

module fp_normalize import fp_add_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  frac_t    sum,
   input  logic     sign_in,
   input  logic     carry_in,
   input  exp_t     exp_in,
   output logic     out_valid,
   output fp_word_t result
);

   logic [4:0]        lz;        // leading zeros of sum
   frac_t             mant;      // hidden bit at msb after shift
   logic signed [9:0] exp_wide;  // room for under / overflow
   logic              is_zero;
   logic              is_sat;
   fp_word_t          res_c;

   // ------------------------------
   // leading-one search
   // ------------------------------
   always_comb begin
      lz = '0;
      for (int i = 0; i < FRAC_W; i++) begin
         if (sum[i]) begin
            lz = 5'(FRAC_W - 1 - i);   // highest set bit wins
         end
      end
   end

   // shift and exponent adjust
   always_comb begin
      if (carry_in) begin
         mant     = {1'b1, sum[FRAC_W-1:1]};                          // carry becomes hidden bit
         exp_wide = $signed({2'b00, exp_in}) + 10'sd1;
      end else begin
         mant     = sum << lz;
         exp_wide = $signed({2'b00, exp_in}) - $signed({5'b00000, lz});
      end
   end

   // ------------------------------
   // zero, saturate, pack
   // ------------------------------
   always_comb begin
      is_zero = (~carry_in & (sum == '0))
              | (exp_in == '0)                           // cancelled in stage 2
              | (exp_wide <= 0);                         // underflow flushes
      is_sat  = (exp_wide > $signed({2'b00, EXP_MAX_NORM}));
      if (is_zero) begin
         res_c = '0;                                     // always +0
      end else if (is_sat) begin
         res_c = {sign_in, EXP_MAX_NORM, {MANT_W{1'b1}}};
      end else begin
         // guard bits dropped, truncation
         res_c = {sign_in, exp_wide[EXP_W-1:0], mant[FRAC_W-2 -: MANT_W]};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      result <= res_c;   // payload
   end

endmodule

/* rtl/fp_add_pipe.sv */
`timescale 1ns/1ps

module fp_add_pipe import fp_add_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     start,
   input  fp_word_t op_a,
   input  fp_word_t op_b,
   input  logic     sub,
   output logic     done,
   output fp_word_t result
);

   // stage 1 -> 2
   logic  s1_valid;
   frac_t s1_frac_big;
   frac_t s1_frac_small;
   logic  s1_sign_big;
   logic  s1_sign_small;
   exp_t  s1_exp;

   // stage 2 -> 3
   logic  s2_valid;
   frac_t s2_sum;
   logic  s2_sign;
   logic  s2_carry;
   exp_t  s2_exp;

   fp_align align0 (
      .clk(clk), .rst(rst), .in_valid(start), .a(op_a), .b(op_b), .sub(sub),
      .out_valid(s1_valid), .frac_big(s1_frac_big), .frac_small(s1_frac_small),
      .sign_big(s1_sign_big), .sign_small_eff(s1_sign_small), .exp_big(s1_exp)
   );

   fp_frac_sub frac_sub0 (
      .clk(clk), .rst(rst), .in_valid(s1_valid),
      .frac1(s1_frac_big), .frac2(s1_frac_small),
      .sign1(s1_sign_big), .sign2(s1_sign_small), .exp_in(s1_exp),
      .out_valid(s2_valid), .sum(s2_sum), .sign_out(s2_sign),
      .carry_out(s2_carry), .exp_out(s2_exp)
   );

   fp_normalize norm0 (
      .clk(clk), .rst(rst), .in_valid(s2_valid), .sum(s2_sum), .sign_in(s2_sign),
      .carry_in(s2_carry), .exp_in(s2_exp), .out_valid(done), .result(result)
   );

endmodule

/* rtl/fp_wb_regs.sv */
`timescale 1ns/1ps

module fp_wb_regs import fp_add_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     cyc,
   input  logic     stb,
   input  logic     we,
   input  wb_addr_t adr,
   input  wb_data_t dat_w,
   output wb_data_t dat_r,
   input  logic [3:0] sel,
   output logic     ack,
   output fp_word_t op_a,
   output fp_word_t op_b,
   output logic     sub,
   output logic     start,
   input  logic     done,
   input  fp_word_t result
);

   wb_state_t   state;
   fp_word_t    op_a_q;
   fp_word_t    op_b_q;
   fp_word_t    result_q;     // last completion
   logic        ctrl_sub_q;
   logic [15:0] done_cnt;     // wraps
   logic [1:0]  inflight;     // ops in pipe, 0..3
   logic        busy;
   logic        req;
   logic        wr_en;
   logic        wr_ctrl;

   assign req = cyc & stb;

   // ------------------------------
   // ack generation
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (req) state <= ST_ACK;
            ST_ACK:  state <= ST_IDLE;      // single-cycle ack
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign ack     = (state == ST_ACK);
   assign wr_en   = ack & req & we & (&sel);     // full-word writes only
   assign wr_ctrl = wr_en & (adr == REG_CTRL);
   assign start   = wr_ctrl;                     // launch in ack cycle
   assign op_a    = op_a_q;
   assign op_b    = op_b_q;
   assign sub     = wr_ctrl ? dat_w[CTRL_SUB_BIT] : ctrl_sub_q;  // live bit on launch
   assign busy    = (inflight != 2'd0);

   // writable registers
   always_ff @(posedge clk) begin
      if (rst) begin
         op_a_q     <= '0;
         op_b_q     <= '0;
         ctrl_sub_q <= 1'b0;
      end else if (wr_en) begin
         case (adr)
            REG_OP_A: op_a_q <= dat_w;
            REG_OP_B: op_b_q <= dat_w;
            REG_CTRL: ctrl_sub_q <= dat_w[CTRL_SUB_BIT];
            default:  ;                           // ro or unmapped
         endcase
      end
   end

   // ------------------------------
   // completion tracking
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         result_q <= '0;
         done_cnt <= '0;
         inflight <= '0;
      end else begin
         if (done) begin
            result_q <= result;
            done_cnt <= done_cnt + 16'd1;
         end
         case ({start, done})
            2'b10:   inflight <= inflight + 2'd1;
            2'b01:   inflight <= inflight - 2'd1;
            default: ;                            // both or neither
         endcase
      end
   end

   // read mux
   always_comb begin
      dat_r = '0;                                 // unmapped reads zero
      case (adr)
         REG_OP_A:   dat_r = op_a_q;
         REG_OP_B:   dat_r = op_b_q;
         REG_CTRL:   dat_r[CTRL_SUB_BIT] = ctrl_sub_q;
         REG_STATUS: dat_r = {done_cnt, 15'd0, busy};
         REG_RESULT: dat_r = result_q;
         default:    ;
      endcase
   end

endmodule

/* rtl/fp_add_top.sv */
`timescale 1ns/1ps

module fp_add_top import fp_add_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       cyc,
   input  logic       stb,
   input  logic       we,
   input  wb_addr_t   adr,
   input  wb_data_t   dat_w,
   output wb_data_t   dat_r,
   input  logic [3:0] sel,
   output logic       ack
);

   fp_word_t op_a;     // slave -> pipe
   fp_word_t op_b;
   logic     sub;
   logic     start;
   logic     done;     // pipe -> slave
   fp_word_t result;

   fp_wb_regs regs0 (
      .clk(clk), .rst(rst),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_w(dat_w), .dat_r(dat_r), .sel(sel), .ack(ack),
      .op_a(op_a), .op_b(op_b), .sub(sub), .start(start),
      .done(done), .result(result)
   );

   fp_add_pipe pipe0 (
      .clk(clk), .rst(rst),
      .start(start), .op_a(op_a), .op_b(op_b), .sub(sub),
      .done(done), .result(result)
   );

endmodule

/* dv/tb_fp_add.sv */
`timescale 1ns/1ps

module tb_fp_add import fp_add_pkg::*; ();

   logic        clk;
   logic        rst;
   logic        cyc;
   logic        stb;
   logic        we;
   wb_addr_t    adr;
   wb_data_t    dat_w;
   wb_data_t    dat_r;
   logic [3:0]  sel;
   logic        ack;
   int          err_cnt;      // all failed checks
   int          test_cnt;
   int          test_fail;
   int          launches;     // ctrl writes since reset
   int unsigned cycle_cnt;    // free-running, for poll timeout

   fp_add_top dut0 (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_w(dat_w), .dat_r(dat_r), .sel(sel), .ack(ack)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // ------------------------------
   // bus tasks
   // ------------------------------
   task automatic stop_on_timeout(input string what);
      $display("timeout: %s did not complete in time", what);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   // caller has already raised cyc/stb; returns in the ack cycle
   task automatic wait_ack(input string what);
      int   n;
      logic got;
      got = 1'b0;
      n   = 0;
      while (!got && n < 20) begin
         @(posedge clk);
         got = ack;   // value held up to this edge
         n++;
      end
      if (!got) stop_on_timeout(what);
   endtask

   task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= addr;
      dat_w <= data;
      sel   <= 4'hf;
      wait_ack("bus write");
      cyc   <= 1'b0;
      stb   <= 1'b0;
      we    <= 1'b0;
   endtask

   task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= addr;
      wait_ack("bus read");
      data = dat_r;   // stable during ack
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   task automatic wait_idle();
      wb_data_t    st;
      int unsigned t0;
      t0 = cycle_cnt;
      st = 32'h1;
      while (st[0]) begin   // busy bit
         if (cycle_cnt - t0 > 50) stop_on_timeout("status poll");
         wb_read(REG_STATUS, st);
      end
   endtask

   // ------------------------------
   // reference model
   // ------------------------------
   function automatic fp_word_t ref_add(input fp_word_t a, input fp_word_t b, input logic do_sub);
      logic        sa;
      logic        sb;
      logic        s_big;
      logic        s_small;
      int          ea;
      int          eb;
      int          e_res;
      int          shift;
      logic [25:0] fa;
      logic [25:0] fb;
      logic [25:0] f_big;
      logic [25:0] f_small;
      logic [26:0] mag;       // one spare bit for the carry
      sa = a[31];
      sb = b[31] ^ do_sub;
      ea = a[30:23];
      eb = b[30:23];
      fa = (ea == 0) ? 26'd0 : {1'b1, a[22:0], 2'b00};   // hidden + 2 guard
      fb = (eb == 0) ? 26'd0 : {1'b1, b[22:0], 2'b00};
      if (ea > eb || (ea == eb && fa >= fb)) begin
         e_res = ea;
         f_big = fa;
         f_small = fb;
         s_big = sa;
         s_small = sb;
         shift = ea - eb;
      end else begin
         e_res = eb;
         f_big = fb;
         f_small = fa;
         s_big = sb;
         s_small = sa;
         shift = eb - ea;
      end
      f_small = (shift >= 26) ? 26'd0 : f_small >> shift;
      if (s_big == s_small) mag = {1'b0, f_big} + {1'b0, f_small};
      else                  mag = {1'b0, f_big} - {1'b0, f_small};
      if (mag == 0) return '0;   // exact zero is +0
      if (mag[26]) begin
         mag = mag >> 1;
         e_res++;
      end else begin
         while (!mag[25]) begin
            mag = mag << 1;
            e_res--;
         end
      end
      if (e_res <= 0) return '0;
      if (e_res > 254) return {s_big, 8'd254, 23'h7fffff};
      return {s_big, e_res[7:0], mag[24:2]};   // guards truncated
   endfunction

   // ------------------------------
   // checks
   // ------------------------------
   task automatic check_word(input string name, input fp_word_t expv, input fp_word_t act);
      if (act !== expv) begin
         $display("ERROR %s: expected %h, actual %h", name, expv, act);
         err_cnt++;
      end
   endtask

   task automatic check_count(input string name, input logic [15:0] expv,
                              input logic [15:0] act);
      if (act !== expv) begin
         $display("ERROR %s: expected %0d, actual %0d", name, expv, act);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic expv, input logic act);
      if (act !== expv) begin
         $display("ERROR %s: expected %b, actual %b", name, expv, act);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         test_fail++;
         $display("test %s: %0d error(s)", name, err_cnt - errs_before);
      end
   endtask

   task automatic run_op(input string name, input fp_word_t a, input fp_word_t b,
                         input logic do_sub, output fp_word_t res);
      wb_data_t st;
      wb_write(REG_OP_A, a);
      wb_write(REG_OP_B, b);
      wb_write(REG_CTRL, {31'd0, do_sub});   // launches in the ack cycle
      launches++;
      wb_read(REG_STATUS, st);
      check_flag({name, "_busy"}, 1'b1, st[0]);   // op still in the pipe
      wait_idle();
      wb_read(REG_RESULT, res);
      check_word(name, ref_add(a, b, do_sub), res);
   endtask

   // ------------------------------
   // tests
   // ------------------------------
   task automatic reset_regs();
      int       e0;
      wb_data_t d;
      e0 = err_cnt;
      wb_read(REG_STATUS, d);
      check_word("reset_status", 32'h0, d);
      wb_write(REG_OP_A, 32'h3fc00000);
      wb_write(REG_OP_B, 32'h40100000);
      wb_read(REG_OP_A, d);
      check_word("readback_a", 32'h3fc00000, d);
      wb_read(REG_OP_B, d);
      check_word("readback_b", 32'h40100000, d);
      wb_write(REG_RESULT, 32'hdeadbeef);   // read-only, ignored
      wb_read(REG_RESULT, d);
      check_word("result_ro", 32'h0, d);
      for (int i = 5; i < 8; i++) begin
         wb_read(wb_addr_t'(i), d);
         check_word("unmapped", 32'h0, d);
      end
      report_test("reset_regs", e0);
   endtask

   task automatic exact_add();
      int       e0;
      fp_word_t r;
      e0 = err_cnt;
      run_op("add_1p5_2p25", 32'h3fc00000, 32'h40100000, 1'b0, r);
      check_word("add_1p5_2p25_lit", 32'h40700000, r);   // 3.75
      run_op("add_carry_a", 32'h3fc00000, 32'h3fc00000, 1'b0, r);
      check_word("add_carry_a_lit", 32'h40400000, r);
      run_op("add_carry_b", 32'h3fe00000, 32'h3fa00000, 1'b0, r);
      run_op("add_neg_pair", 32'hc0a00000, 32'hc0e00000, 1'b0, r);
      report_test("exact_add", e0);
   endtask

   task automatic sub_cancel();
      int       e0;
      fp_word_t r;
      e0 = err_cnt;
      run_op("sub_close", 32'h3f800001, 32'h3f800000, 1'b1, r);
      check_word("sub_close_lit", 32'h34000000, r);   // 2^-23
      run_op("sub_self", 32'h40490fdb, 32'h40490fdb, 1'b1, r);
      check_word("sub_self_lit", 32'h0, r);
      run_op("sub_neg", 32'h40000000, 32'h40400000, 1'b1, r);
      check_word("sub_neg_lit", 32'hbf800000, r);     // -1.0
      run_op("sub_mixed", 32'hc1200000, 32'hc1100001, 1'b1, r);
      report_test("sub_cancel", e0);
   endtask

   task automatic align_limits();
      int       e0;
      fp_word_t r;
      e0 = err_cnt;
      run_op("diff1_add", 32'h40400000, 32'h3fc00000, 1'b0, r);
      run_op("diff1_sub", 32'h40000000, 32'h3fc00000, 1'b1, r);
      run_op("diff25", 32'h4c000000, 32'h3f800000, 1'b0, r);
      check_word("diff25_lit", 32'h4c000000, r);
      run_op("diff30", 32'h4e800000, 32'h3f800000, 1'b1, r);
      check_word("diff30_lit", 32'h4e800000, r);   // small one lost
      run_op("zero_a", 32'h0, 32'h40490fdb, 1'b0, r);
      check_word("zero_a_lit", 32'h40490fdb, r);
      run_op("zero_b", 32'hc0490fdb, 32'h0, 1'b1, r);
      check_word("zero_b_lit", 32'hc0490fdb, r);
      report_test("align_limits", e0);
   endtask

   task automatic saturation();
      int       e0;
      fp_word_t r;
      e0 = err_cnt;
      run_op("sat_pos", 32'h7f7fffff, 32'h7f7fffff, 1'b0, r);
      check_word("sat_pos_lit", 32'h7f7fffff, r);
      run_op("sat_neg", 32'hff000000, 32'h7f000000, 1'b1, r);
      check_word("sat_neg_lit", 32'hff7fffff, r);
      report_test("saturation", e0);
   endtask

   task automatic random_ops();
      int       e0;
      fp_word_t a;
      fp_word_t b;
      fp_word_t r;
      wb_data_t st;
      e0 = err_cnt;
      for (int i = 0; i < 40; i++) begin
         a = $urandom;
         b = $urandom;
         if (i % 2) b[30:23] = a[30:23] + 8'($urandom % 3);   // near cancellation
         run_op("random", a, b, 1'($urandom), r);
      end
      wb_read(REG_STATUS, st);
      check_count("done_count", 16'(launches), st[31:16]);
      report_test("random", e0);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      void'($urandom(78));
      cycle_cnt = 0;
      err_cnt   = 0;
      test_cnt  = 0;
      test_fail = 0;
      launches  = 0;
      rst   <= 1'b1;
      cyc   <= 1'b0;
      stb   <= 1'b0;
      we    <= 1'b0;
      adr   <= '0;
      dat_w <= '0;
      sel   <= 4'h0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      reset_regs();
      exact_add();
      sub_cancel();
      align_limits();
      saturation();
      random_ops();
      $display("tests run %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* build.f */
rtl/fp_add_pkg.sv
rtl/fp_align.sv
rtl/fp_frac_sub.sv
rtl/fp_normalize.sv
rtl/fp_add_pipe.sv
rtl/fp_wb_regs.sv
rtl/fp_add_top.sv
dv/tb_fp_add.sv

/* Bender.yml */
package:
  name: fp_add

sources:
  - rtl/fp_add_pkg.sv
  - rtl/fp_align.sv
  - rtl/fp_frac_sub.sv
  - rtl/fp_normalize.sv
  - rtl/fp_add_pipe.sv
  - rtl/fp_wb_regs.sv
  - rtl/fp_add_top.sv
  - target: simulation
    files:
      - dv/tb_fp_add.sv
